// ==== common/alu_params.svh ====
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Operand and result width.
`define ALU_DATA_W 32

// Register index width. Wide enough for the dummy index.
`define ALU_IDX_W 6

// Architectural index of the program counter.
`define ALU_PC_INDEX 15

// Index written in place of the PC destination.
`define ALU_DUMMY_INDEX 32

`endif

// ==== common/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

        // Data processing opcodes, ARM encoding.
        typedef enum logic [3:0] {
                OP_AND = 4'd0,
                OP_EOR = 4'd1,
                OP_SUB = 4'd2,
                OP_RSB = 4'd3,
                OP_ADD = 4'd4,
                OP_ADC = 4'd5,
                OP_SBC = 4'd6,
                OP_RSC = 4'd7,
                OP_TST = 4'd8,
                OP_TEQ = 4'd9,
                OP_CMP = 4'd10,
                OP_CMN = 4'd11,
                OP_ORR = 4'd12,
                OP_MOV = 4'd13,
                OP_BIC = 4'd14,
                OP_MVN = 4'd15
        } alu_op_t;

        // Condition field, bits 31:28 of the instruction.
        typedef enum logic [3:0] {
                EQ = 4'd0,  NE = 4'd1,  CS = 4'd2,  CC = 4'd3,
                MI = 4'd4,  PL = 4'd5,  VS = 4'd6,  VC = 4'd7,
                HI = 4'd8,  LS = 4'd9,  GE = 4'd10, LT = 4'd11,
                GT = 4'd12, LE = 4'd13, AL = 4'd14, NV = 4'd15
        } cond_t;

        typedef enum logic {
                RUN   = 1'b0,
                SLEEP = 1'b1
        } alu_state_t;

        // Positions within the 4-bit flag vector.
        localparam int unsigned FLAG_N = 3;
        localparam int unsigned FLAG_Z = 2;
        localparam int unsigned FLAG_C = 1;
        localparam int unsigned FLAG_V = 0;

endpackage

`default_nettype wire

// ==== alu/alu_cond_check.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_cond_check (
        input  alu_pkg::cond_t  i_cond,
        input  logic [3:0]      i_flags,        // N, Z, C, V.
        output logic            o_execute
);
        import alu_pkg::*;

        logic n;
        logic z;
        logic c;
        logic v;

        assign n = i_flags[FLAG_N];
        assign z = i_flags[FLAG_Z];
        assign c = i_flags[FLAG_C];
        assign v = i_flags[FLAG_V];

        always_comb
        begin
                case (i_cond)
                EQ:      o_execute = z;
                NE:      o_execute = !z;
                CS:      o_execute = c;
                CC:      o_execute = !c;
                MI:      o_execute = n;
                PL:      o_execute = !n;
                VS:      o_execute = v;
                VC:      o_execute = !v;
                HI:      o_execute = c && !z;        // Unsigned higher.
                LS:      o_execute = !c || z;
                GE:      o_execute = (n == v);       // Signed compares.
                LT:      o_execute = (n != v);
                GT:      o_execute = !z && (n == v);
                LE:      o_execute = z || (n != v);
                AL:      o_execute = 1'b1;
                default: o_execute = 1'b0;           // NV.
                endcase
        end

endmodule

`default_nettype wire

// ==== alu/alu_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "alu_params.svh"

module alu_datapath (
        input  alu_pkg::alu_op_t        i_op,
        input  logic [`ALU_DATA_W-1:0]  i_rn,
        input  logic [`ALU_DATA_W-1:0]  i_rm,
        input  logic [3:0]              i_flags,
        input  logic                    i_flag_update,
        input  logic                    i_valid,
        output logic [`ALU_DATA_W-1:0]  o_result,
        output logic [3:0]              o_flags_nxt
);
        import alu_pkg::*;

        localparam int MSB = `ALU_DATA_W - 1;

        logic                   is_logical;
        logic [`ALU_DATA_W-1:0] logic_res;
        logic [`ALU_DATA_W-1:0] add_a;
        logic [`ALU_DATA_W-1:0] add_b;
        logic                   add_cin;
        logic [`ALU_DATA_W:0]   add_sum;
        logic                   add_v;

        // Logical group. TST and TEQ still drive the result.
        always_comb
        begin
                is_logical = 1'b1;
                logic_res  = '0;
                case (i_op)
                OP_AND, OP_TST: logic_res = i_rn & i_rm;
                OP_EOR, OP_TEQ: logic_res = i_rn ^ i_rm;
                OP_BIC:         logic_res = i_rn & ~i_rm;
                OP_MOV:         logic_res = i_rm;
                OP_MVN:         logic_res = ~i_rm;
                OP_ORR:         logic_res = i_rn | i_rm;
                default:        is_logical = 1'b0;
                endcase
        end

        // One adder for all arithmetic ops; subtraction adds the inverted operand.
        always_comb
        begin
                add_a   = i_rn;
                add_b   = i_rm;
                add_cin = 1'b0;
                case (i_op)
                OP_SUB, OP_CMP:
                begin
                        add_b   = ~i_rm;
                        add_cin = 1'b1;
                end
                OP_RSB:
                begin
                        add_a   = i_rm;
                        add_b   = ~i_rn;
                        add_cin = 1'b1;
                end
                OP_SBC:
                begin
                        add_b   = ~i_rm;
                        add_cin = i_flags[FLAG_C];   // Borrow is not C.
                end
                OP_RSC:
                begin
                        add_a   = i_rm;
                        add_b   = ~i_rn;
                        add_cin = i_flags[FLAG_C];
                end
                OP_ADC:  add_cin = i_flags[FLAG_C];
                default: add_cin = 1'b0;             // ADD, CMN.
                endcase
        end

        assign add_sum = {1'b0, add_a} + {1'b0, add_b} + {{`ALU_DATA_W{1'b0}}, add_cin};

        // Same-sign inputs giving a different-sign sum.
        assign add_v = (add_a[MSB] == add_b[MSB]) && (add_sum[MSB] != add_a[MSB]);

        assign o_result = is_logical ? logic_res : add_sum[MSB:0];

        always_comb
        begin
                o_flags_nxt = i_flags;
                if (i_valid && i_flag_update)
                begin
                        o_flags_nxt[FLAG_N] = o_result[MSB];
                        o_flags_nxt[FLAG_Z] = (o_result == '0);
                        if (!is_logical)
                        begin
                                o_flags_nxt[FLAG_C] = add_sum[`ALU_DATA_W]; // Carry out.
                                o_flags_nxt[FLAG_V] = add_v;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== alu/alu_sleep_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_sleep_fsm (
        input  logic    i_clk,
        input  logic    i_reset,
        input  logic    i_clear,        // From writeback, highest priority.
        input  logic    i_stall,
        input  logic    i_exception,
        input  logic    i_execute,      // Condition passed.
        output logic    o_sleeping,
        output logic    o_valid
);
        import alu_pkg::*;

        alu_state_t state_ff;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_ff <= RUN;
                end
                else if (i_clear)
                begin
                        state_ff <= RUN;        // Only way out of SLEEP.
                end
                else if (!i_stall)
                begin
                        case (state_ff)
                        RUN:
                        begin
                                if (i_exception)
                                        state_ff <= SLEEP;
                        end
                        default: state_ff <= SLEEP;
                        endcase
                end
        end

        assign o_sleeping = (state_ff == SLEEP);

        // An exception marker never executes.
        assign o_valid = i_execute && !i_exception && !o_sleeping;

endmodule

`default_nettype wire

// ==== alu/alu_output_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "alu_params.svh"

module alu_output_stage (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_clear,
        input  logic                    i_stall,
        input  logic                    i_sleeping,
        input  logic                    i_valid,
        input  logic [`ALU_DATA_W-1:0]  i_result,
        input  logic [3:0]              i_flags_nxt,
        input  logic [`ALU_DATA_W-1:0]  i_rn,
        input  logic                    i_pre_index,
        input  logic [`ALU_IDX_W-1:0]   i_dest_index,
        output logic [`ALU_DATA_W-1:0]  o_result,
        output logic                    o_dav,
        output logic [`ALU_DATA_W-1:0]  o_mem_address,
        output logic [`ALU_IDX_W-1:0]   o_dest_index,
        output logic [3:0]              o_flags,
        output logic                    o_clear_from_alu,
        output logic [`ALU_DATA_W-1:0]  o_pc_from_alu
);
        localparam logic [`ALU_IDX_W-1:0] PC_INDEX    = `ALU_PC_INDEX;
        localparam logic [`ALU_IDX_W-1:0] DUMMY_INDEX = `ALU_DUMMY_INDEX;

        logic [`ALU_DATA_W-1:0] mem_address_nxt;
        logic [`ALU_IDX_W-1:0]  dest_index_nxt;
        logic                   dest_is_pc;

        assign dest_is_pc      = (i_dest_index == PC_INDEX);
        assign mem_address_nxt = i_pre_index ? i_rn : i_result;  // Pre or post index.
        assign dest_index_nxt  = dest_is_pc ? DUMMY_INDEX : i_dest_index;

        // Branch redirect in the same cycle.
        assign o_clear_from_alu = dest_is_pc && i_valid;
        assign o_pc_from_alu    = o_clear_from_alu ? i_result : '0;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_result      <= '0;
                        o_dav         <= 1'b0;
                        o_mem_address <= '0;
                        o_dest_index  <= '0;
                        o_flags       <= '0;
                end
                else if (i_clear || (i_sleeping && !i_stall))
                begin
                        // Flags survive a flush and sleep.
                        o_result      <= '0;
                        o_dav         <= 1'b0;
                        o_mem_address <= '0;
                        o_dest_index  <= '0;
                end
                else if (!i_stall)
                begin
                        o_result      <= i_result;
                        o_dav         <= i_valid;
                        o_mem_address <= mem_address_nxt;
                        o_dest_index  <= dest_index_nxt;
                        o_flags       <= i_flags_nxt;   // Old flags unless updated.
                end
        end

endmodule

`default_nettype wire

// ==== alu/alu_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "alu_params.svh"

module alu_top (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_clear_from_writeback,
        input  logic                    i_data_stall,
        input  logic [`ALU_DATA_W-1:0]  i_rn,
        input  logic [`ALU_DATA_W-1:0]  i_rm,
        input  alu_pkg::alu_op_t        i_op,
        input  alu_pkg::cond_t          i_cond,
        input  logic                    i_flag_update,
        input  logic [`ALU_IDX_W-1:0]   i_dest_index,
        input  logic                    i_pre_index,
        input  logic                    i_exception,
        output logic [`ALU_DATA_W-1:0]  o_result,
        output logic                    o_dav,
        output logic [`ALU_DATA_W-1:0]  o_mem_address,
        output logic [`ALU_IDX_W-1:0]   o_dest_index,
        output logic [3:0]              o_flags,
        output logic                    o_clear_from_alu,
        output logic [`ALU_DATA_W-1:0]  o_pc_from_alu
);
        logic                   execute;
        logic                   valid;
        logic                   sleeping;
        logic [`ALU_DATA_W-1:0] result_nxt;
        logic [3:0]             flags_nxt;

        alu_cond_check u_cond_check (
                .i_cond         (i_cond),
                .i_flags        (o_flags),      // Stored flags.
                .o_execute      (execute)
        );

        alu_datapath u_datapath (
                .i_op           (i_op),
                .i_rn           (i_rn),
                .i_rm           (i_rm),
                .i_flags        (o_flags),
                .i_flag_update  (i_flag_update),
                .i_valid        (valid),
                .o_result       (result_nxt),
                .o_flags_nxt    (flags_nxt)
        );

        alu_sleep_fsm u_sleep_fsm (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_clear        (i_clear_from_writeback),
                .i_stall        (i_data_stall),
                .i_exception    (i_exception),
                .i_execute      (execute),
                .o_sleeping     (sleeping),
                .o_valid        (valid)
        );

        alu_output_stage u_output_stage (
                .i_clk            (i_clk),
                .i_reset          (i_reset),
                .i_clear          (i_clear_from_writeback),
                .i_stall          (i_data_stall),
                .i_sleeping       (sleeping),
                .i_valid          (valid),
                .i_result         (result_nxt),
                .i_flags_nxt      (flags_nxt),
                .i_rn             (i_rn),
                .i_pre_index      (i_pre_index),
                .i_dest_index     (i_dest_index),
                .o_result         (o_result),
                .o_dav            (o_dav),
                .o_mem_address    (o_mem_address),
                .o_dest_index     (o_dest_index),
                .o_flags          (o_flags),
                .o_clear_from_alu (o_clear_from_alu),
                .o_pc_from_alu    (o_pc_from_alu)
        );

endmodule

`default_nettype wire

// ==== verification/alu_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "alu_params.svh"

module alu_asserts (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_clear,
        input  logic                    i_stall,
        input  logic                    i_sleeping,
        input  logic [`ALU_IDX_W-1:0]   i_dest_index,
        input  logic                    i_branch,
        input  logic [`ALU_DATA_W-1:0]  i_branch_pc,
        input  logic                    i_dav,
        input  logic [`ALU_DATA_W-1:0]  i_result,
        input  logic [`ALU_IDX_W-1:0]   i_reg_dest_index
);
        localparam logic [`ALU_IDX_W-1:0] PC_INDEX    = `ALU_PC_INDEX;
        localparam logic [`ALU_IDX_W-1:0] DUMMY_INDEX = `ALU_DUMMY_INDEX;

        int unsigned fail_count = 0;    // Failed assertions so far.

        // A taken redirect lands as a valid result holding its own target.
        redirect_lands: assert property (@(posedge i_clk) disable iff (i_reset)
                i_branch && !i_stall && !i_clear
                |=> i_dav && (i_result == $past(i_branch_pc)))
        else
        begin
                $error("Branch redirect not followed by a valid result at its target.");
                fail_count++;
        end

        // A flush leaves nothing valid behind.
        clear_kills_dav: assert property (@(posedge i_clk) disable iff (i_reset)
                i_clear |=> !i_dav)
        else
        begin
                $error("Result still valid after a writeback clear.");
                fail_count++;
        end

        sleep_no_dav: assert property (@(posedge i_clk) disable iff (i_reset)
                i_sleeping |-> !i_dav)
        else
        begin
                $error("Result valid while the stage sleeps.");
                fail_count++;
        end

        // A PC destination is registered as the dummy index.
        no_pc_dest: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_dest_index == PC_INDEX) && !i_stall && !i_clear && !i_sleeping
                |=> (i_reg_dest_index == DUMMY_INDEX))
        else
        begin
                $error("PC destination not remapped to the dummy index.");
                fail_count++;
        end

endmodule

bind alu_top alu_asserts u_asserts (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_clear          (i_clear_from_writeback),
        .i_stall          (i_data_stall),
        .i_sleeping       (sleeping),
        .i_dest_index     (i_dest_index),
        .i_branch         (o_clear_from_alu),
        .i_branch_pc      (o_pc_from_alu),
        .i_dav            (o_dav),
        .i_result         (o_result),
        .i_reg_dest_index (o_dest_index)
);

`default_nettype wire

// ==== verification/alu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "alu_params.svh"

module alu_tb;
        import alu_pkg::*;

        localparam int RESET_CYCLES   = 10;
        localparam int SETTLE_TIMEOUT = 20;
        localparam int COMB_DELAY     = 2;      // Into the low clock phase.

        logic                   i_clk;
        logic                   i_reset;
        logic                   i_clear_from_writeback;
        logic                   i_data_stall;
        logic [`ALU_DATA_W-1:0] i_rn;
        logic [`ALU_DATA_W-1:0] i_rm;
        alu_op_t                i_op;
        cond_t                  i_cond;
        logic                   i_flag_update;
        logic [`ALU_IDX_W-1:0]  i_dest_index;
        logic                   i_pre_index;
        logic                   i_exception;
        logic [`ALU_DATA_W-1:0] o_result;
        logic                   o_dav;
        logic [`ALU_DATA_W-1:0] o_mem_address;
        logic [`ALU_IDX_W-1:0]  o_dest_index;
        logic [3:0]             o_flags;
        logic                   o_clear_from_alu;
        logic [`ALU_DATA_W-1:0] o_pc_from_alu;

        logic [8*160-1:0]       text_line;
        logic [8*16-1:0]        test_name;
        logic [31:0]            f_stall, f_clear, f_exc, f_op, f_cond, f_fu, f_dest, f_pre;
        logic [31:0]            f_rn, f_rm;
        logic [31:0]            e_clr, e_pc, e_result, e_dav, e_addr, e_dest, e_flags;
        integer                 seed;
        integer                 fd;
        integer                 fields;
        int                     tests;
        int                     failed_tests;
        int                     other_errors;
        int                     step_errors;
        int                     cycles;
        logic                   settled;

        alu_top i_dut (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_data_stall           (i_data_stall),
                .i_rn                   (i_rn),
                .i_rm                   (i_rm),
                .i_op                   (i_op),
                .i_cond                 (i_cond),
                .i_flag_update          (i_flag_update),
                .i_dest_index           (i_dest_index),
                .i_pre_index            (i_pre_index),
                .i_exception            (i_exception),
                .o_result               (o_result),
                .o_dav                  (o_dav),
                .o_mem_address          (o_mem_address),
                .o_dest_index           (o_dest_index),
                .o_flags                (o_flags),
                .o_clear_from_alu       (o_clear_from_alu),
                .o_pc_from_alu          (o_pc_from_alu)
        );

        initial
        begin
                i_clk = 1'b0;
                forever #4 i_clk = ~i_clk;      // 8 ns period.
        end

        task automatic compare(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
                if (actual !== expected)
                begin
                        $display("ERROR %0s %0s expected %h actual %h",
                                 test_name, what, expected, actual);
                        step_errors = step_errors + 1;
                end
        endtask

        // Drives one pattern line on a falling edge and checks both output groups.
        task run_step;
                step_errors            = 0;
                i_data_stall           = f_stall[0];
                i_clear_from_writeback = f_clear[0];
                i_exception            = f_exc[0];
                i_op                   = alu_op_t'(f_op[3:0]);
                i_cond                 = cond_t'(f_cond[3:0]);
                i_flag_update          = f_fu[0];
                i_dest_index           = f_dest[`ALU_IDX_W-1:0];
                i_pre_index            = f_pre[0];
                i_rn                   = f_rn;
                i_rm                   = f_rm;
                if (f_stall[0])
                begin
                        i_rn = $random(seed);   // Lost input.
                        i_rm = $random(seed);
                end
                #COMB_DELAY;
                compare("clear_from_alu", e_clr, {31'd0, o_clear_from_alu});
                compare("pc_from_alu", e_pc, o_pc_from_alu);
                @(negedge i_clk);
                compare("result", e_result, o_result);
                compare("dav", e_dav, {31'd0, o_dav});
                compare("mem_address", e_addr, o_mem_address);
                compare("dest_index", e_dest, {{(32-`ALU_IDX_W){1'b0}}, o_dest_index});
                compare("flags", e_flags, {28'd0, o_flags});
                tests = tests + 1;
                if (step_errors == 0)
                        $display("%0s: ok", test_name);
                else
                begin
                        $display("%0s: %0d mismatches", test_name, step_errors);
                        failed_tests = failed_tests + 1;
                end
        endtask

        initial
        begin
                seed                   = 72992;
                tests                  = 0;
                failed_tests           = 0;
                other_errors           = 0;
                i_reset                = 1'b1;
                i_clear_from_writeback = 1'b0;
                i_data_stall           = 1'b0;
                i_rn                   = '0;
                i_rm                   = '0;
                i_op                   = OP_AND;
                i_cond                 = NV;    // Idle. NV never executes.
                i_flag_update          = 1'b0;
                i_dest_index           = '0;
                i_pre_index            = 1'b0;
                i_exception            = 1'b0;
                repeat (RESET_CYCLES) @(posedge i_clk);
                @(negedge i_clk);
                i_reset = 1'b0;

                settled = 1'b0;
                cycles  = 0;
                while (!settled && cycles < SETTLE_TIMEOUT)
                begin
                        @(negedge i_clk);
                        cycles = cycles + 1;
                        if (o_dav === 1'b0 && o_flags === 4'h0)
                                settled = 1'b1;
                end

                if (!settled)
                begin
                        $display("Timeout: outputs not idle %0d cycles after reset.", cycles);
                        other_errors = other_errors + 1;
                end
                else
                begin
                        fd = $fopen("verification/alu_patterns.txt", "r");
                        if (fd == 0)
                        begin
                                $display("Could not open verification/alu_patterns.txt.");
                                other_errors = other_errors + 1;
                        end
                        else
                        begin
                                while (!$feof(fd))
                                begin
                                        text_line = '0;
                                        void'($fgets(text_line, fd));
                                        fields = $sscanf(text_line,
                                                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                                test_name, f_stall, f_clear, f_exc, f_op, f_cond,
                                                f_fu, f_dest, f_pre, f_rn, f_rm, e_clr, e_pc,
                                                e_result, e_dav, e_addr, e_dest, e_flags);
                                        if (fields == 18)       // Comments and blanks skip.
                                                run_step();
                                end
                                $fclose(fd);
                        end
                end

                if (tests == 0)
                begin
                        $display("No pattern lines were run.");
                        other_errors = other_errors + 1;
                end
                $display("Summary: %0d tests, %0d failed, %0d other errors, %0d assertion failures",
                         tests, failed_tests, other_errors, i_dut.u_asserts.fail_count);
                if (failed_tests == 0 && other_errors == 0 && i_dut.u_asserts.fail_count == 0)
                        $display("TEST PASS");
                else
                        $display("TEST FAIL");
                $finish;
        end

endmodule

`default_nettype wire

// ==== verification/alu_patterns.txt ====
# test stall clear exc op cond fu dest pre rn rm | clr pc | result dav addr dest flags
# Hex fields; the registered group is seen one cycle after the inputs.
add_cv 0 0 0 4 1 1 02 0 80000000 80000000 0 0 00000000 1 00000000 02 7
and_keep 0 0 0 0 0 1 03 1 ffff0000 0f0f0f0f 0 0 0f0f0000 1 ffff0000 03 3
tst_neg 0 0 0 8 8 1 04 0 80000001 80000000 0 0 80000000 1 80000000 04 b
teq_zero 0 0 0 9 a 1 05 0 12345678 12345678 0 0 00000000 1 00000000 05 7
eor 0 0 0 1 b 1 06 0 a5a5a5a5 ffffffff 0 0 5a5a5a5a 1 5a5a5a5a 06 3
bic 0 0 0 e 2 1 07 1 ffffffff 0000ffff 0 0 ffff0000 1 ffffffff 07 b
orr 0 0 0 c 4 1 08 0 00f00000 0000000f 0 0 00f0000f 1 00f0000f 08 3
mvn 0 0 0 f 6 1 09 0 11111111 00000000 0 0 ffffffff 1 ffffffff 09 b
mov_zero 0 0 0 d c 1 0a 0 00000000 00000000 0 0 00000000 1 00000000 0a 7
adc_cin 0 0 0 5 d 1 0b 0 00000001 00000002 0 0 00000004 1 00000004 0b 0
sbc_cin0 0 0 0 6 3 1 0c 0 00000010 00000005 0 0 0000000a 1 0000000a 0c 2
rsc_cin1 0 0 0 7 5 1 0d 0 00000005 00000003 0 0 fffffffe 1 fffffffe 0d 8
sbc_ovf 0 0 0 6 7 1 0e 1 80000000 00000000 0 0 7fffffff 1 80000000 0e 3
adc_ovf 0 0 0 5 e 1 01 0 7fffffff 00000000 0 0 80000000 1 80000000 01 9
sub_zero 0 0 0 2 9 1 02 0 00000005 00000005 0 0 00000000 1 00000000 02 6
rsb_neg 0 0 0 3 e 1 03 0 00000001 00000000 0 0 ffffffff 1 ffffffff 03 8
cmp_lt 0 0 0 a e 1 04 0 00000003 00000007 0 0 fffffffc 1 fffffffc 04 8
cmn_zero 0 0 0 b e 1 05 0 ffffffff 00000001 0 0 00000000 1 00000000 05 6
add_nofu 0 0 0 4 e 0 06 0 00000001 00000001 0 0 00000002 1 00000002 06 6
ne_fail 0 0 0 4 1 1 07 0 00000001 00000002 0 0 00000003 0 00000003 07 6
nv_fail 0 0 0 d f 1 08 0 00000000 00000055 0 0 00000055 0 00000055 08 6
mi_fail 0 0 0 d 4 1 09 0 00000000 80000000 0 0 80000000 0 80000000 09 6
hi_fail 0 0 0 d 8 1 0a 0 00000000 00000000 0 0 00000000 0 00000000 0a 6
pc_branch 0 0 0 4 e 0 0f 0 00001000 00000008 1 00001008 00001008 1 00001008 20 6
stall_hold 1 0 0 4 e 1 04 0 00000000 00000000 0 0 00001008 1 00001008 20 6
pc_condfail 0 0 0 4 1 1 0f 0 00001000 00000008 0 0 00001008 0 00001008 20 6
exc_mark 0 0 1 4 e 1 02 0 00000001 00000001 0 0 00000002 0 00000002 02 6
sleep_al 0 0 0 d e 1 0f 0 00000000 12345678 0 0 00000000 0 00000000 00 6
sleep_add 0 0 0 4 e 1 03 1 00000005 00000005 0 0 00000000 0 00000000 00 6
wb_clear 0 1 0 d e 1 01 0 00000000 00000001 0 0 00000000 0 00000000 00 6
run_again 0 0 0 2 e 1 05 0 00000009 00000004 0 0 00000005 1 00000005 05 2
pre_index 0 0 0 4 e 0 06 1 00002000 00000010 0 0 00002010 1 00002000 06 2

// ==== flist.f ====
+incdir+common
common/alu_pkg.sv
alu/alu_cond_check.sv
alu/alu_datapath.sv
alu/alu_sleep_fsm.sv
alu/alu_output_stage.sv
alu/alu_top.sv
verification/alu_asserts.sv
verification/alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the ALU stage testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module alu_tb -f flist.f -Mdir obj_dir -o alu_sim
./obj_dir/alu_sim 2>&1 | tee sim.log

if grep -q "^TEST PASS$" sim.log
then
    echo "Simulation passed."
else
    echo "Simulation failed."
    exit 1
fi
